// ==== source/text_term_pkg.sv ====
package text_term_pkg;

    // Screen geometry
    localparam int N_COLS = 60;
    localparam int N_ROWS = 17;
    localparam int COL_W  = 6;                  // Holds 0..63
    localparam int ROW_W  = 5;                  // Holds 0..31
    localparam int ADDR_W = ROW_W + COL_W;      // 11 bit VRAM address

    // Keys
    localparam int N_KEYS    = 2;
    localparam int KEY_PUT   = 0;
    localparam int KEY_CLEAR = 1;
    // Short repeat intervals so a held key repeats within a short simulation
    localparam logic [N_KEYS-1:0][31:0] KEY_REPEAT_TICKS = {32'd150, 32'd40};

    localparam logic [7:0] BLANK_CHAR = 8'h20;  // ASCII space

    // Scan blanking
    localparam int H_BLANK       = 8;           // Clocks after each row
    localparam int V_BLANK_LINES = 2;           // Lines after row 16

    // VRAM address, row above column
    typedef union packed {
        logic [ADDR_W-1:0] linear;              // Memory index
        struct packed {
            logic [ROW_W-1:0] row;
            logic [COL_W-1:0] col;
        } rc;
    } vram_addr_u;

endpackage

// ==== source/key_repeat.sv ====
`timescale 1ns/1ps

module key_repeat #(
    parameter int unsigned P_REPEAT = 1000     // Clocks between repeat pulses
) (
    input  logic CLK_12MHZ,
    input  logic i_rst,
    input  logic i_btn,                        // Debounced, active high
    output logic o_pulse                       // One clock per press or repeat
);

    logic        btn_s1;                       // Sync stage 1
    logic        btn_s2;                       // Sync stage 2
    logic        btn_prev;                     // Edge register
    logic [31:0] rpt_cnt;                      // Clocks since last pulse

    always_ff @(posedge CLK_12MHZ) begin
        if (i_rst) begin
            btn_s1   <= 1'b0;
            btn_s2   <= 1'b0;
            btn_prev <= 1'b0;
            rpt_cnt  <= '0;
            o_pulse  <= 1'b0;
        end else begin
            btn_s1   <= i_btn;
            btn_s2   <= btn_s1;
            btn_prev <= btn_s2;
            o_pulse  <= 1'b0;
            if (!btn_s2) begin
                rpt_cnt <= '0;                 // Released, nothing pending
            end else if (!btn_prev) begin
                rpt_cnt <= 32'd1;              // Press edge
                o_pulse <= 1'b1;
            end else if (rpt_cnt == P_REPEAT) begin
                rpt_cnt <= 32'd1;              // Interval elapsed while held
                o_pulse <= 1'b1;
            end else begin
                rpt_cnt <= rpt_cnt + 32'd1;
            end
        end
    end

    // A stretched pulse would put the same character twice
    a_single_pulse: assert property (@(posedge CLK_12MHZ) disable iff (i_rst)
        o_pulse |=> !o_pulse);

endmodule

// ==== source/vram.sv ====
`timescale 1ns/1ps

module vram
    import text_term_pkg::*;
(
    input  logic              CLK_12MHZ,
    input  logic              i_a_ce,          // Port A enable
    input  logic              i_a_we,          // Port A write
    input  logic [ADDR_W-1:0] i_a_addr,
    input  logic [7:0]        i_a_din,
    output logic [7:0]        o_a_dout,        // Valid one clock after read
    input  logic [ADDR_W-1:0] i_b_addr,        // Scan read address
    output logic [7:0]        o_b_dout
);

    logic [7:0] mem [2**ADDR_W];               // One byte per cell
    vram_addr_u a_addr;

    assign a_addr = i_a_addr;

    // Port A, read before write
    always_ff @(posedge CLK_12MHZ) begin
        if (i_a_ce) begin
            if (i_a_we) begin
                mem[a_addr.linear] <= i_a_din;
            end
            o_a_dout <= mem[a_addr.linear];
        end
    end

    // Port B, read only
    always_ff @(posedge CLK_12MHZ) begin
        o_b_dout <= mem[i_b_addr];
    end

    // Columns 60..63 lie off screen, no writer may reach them
    a_col_in_range: assert property (@(posedge CLK_12MHZ)
        (i_a_ce && i_a_we) |-> (a_addr.rc.col < N_COLS));

endmodule

// ==== source/clear_engine.sv ====
`timescale 1ns/1ps

module clear_engine
    import text_term_pkg::*;
(
    input  logic              CLK_12MHZ,
    input  logic              i_rst,
    input  logic              i_start,         // One clock strobe
    output logic              o_running,       // Busy until last cell written
    output logic [ADDR_W-1:0] o_vram_addr,
    output logic              o_vram_ce,
    output logic              o_vram_we,
    output logic [7:0]        o_vram_din
);

    vram_addr_u addr_q;                        // Cell being blanked

    always_ff @(posedge CLK_12MHZ) begin
        if (i_rst) begin
            o_running <= 1'b0;
            addr_q    <= '0;
        end else if (i_start) begin
            o_running <= 1'b1;
            addr_q    <= '0;                   // Start at home cell
        end else if (o_running) begin
            if (addr_q.rc.col == COL_W'(N_COLS - 1)) begin
                addr_q.rc.col <= '0;
                if (addr_q.rc.row == ROW_W'(N_ROWS - 1)) begin
                    o_running <= 1'b0;         // 1020th write done
                end else begin
                    addr_q.rc.row <= addr_q.rc.row + 1'b1;
                end
            end else begin
                addr_q.rc.col <= addr_q.rc.col + 1'b1;
            end
        end
    end

    // One blank write per running clock
    assign o_vram_addr = addr_q.linear;
    assign o_vram_ce   = o_running;
    assign o_vram_we   = o_running;
    assign o_vram_din  = BLANK_CHAR;

endmodule

// ==== source/scroll_engine.sv ====
`timescale 1ns/1ps

module scroll_engine
    import text_term_pkg::*;
(
    input  logic              CLK_12MHZ,
    input  logic              i_rst,
    input  logic              i_start,         // One clock strobe
    output logic              o_running,
    output logic [ADDR_W-1:0] o_vram_addr,
    output logic              o_vram_ce,
    output logic              o_vram_we,
    input  logic [7:0]        i_vram_dout,     // Port A read data
    output logic [7:0]        o_vram_din
);

    logic [ROW_W-1:0] row_q;                   // Destination row
    logic [COL_W-1:0] col_q;
    logic [1:0]       step_q;                  // 0 read, 1 capture, 2 write
    logic             blank_q;                 // Blanking row 16
    logic             rd;
    logic             wr;
    logic [7:0]       data_q;                  // Character being moved up
    vram_addr_u       src_addr;
    vram_addr_u       dst_addr;

    always_comb begin
        dst_addr.rc.row = row_q;
        dst_addr.rc.col = col_q;
        src_addr.rc.row = row_q + 1'b1;        // One row below
        src_addr.rc.col = col_q;
    end

    assign rd          = o_running && !blank_q && (step_q == 2'd0);
    assign wr          = o_running && (blank_q || (step_q == 2'd2));
    assign o_vram_addr = rd ? src_addr.linear : dst_addr.linear;
    assign o_vram_ce   = rd || wr;
    assign o_vram_we   = wr;
    assign o_vram_din  = blank_q ? BLANK_CHAR : data_q;

    always_ff @(posedge CLK_12MHZ) begin
        if (step_q == 2'd1) begin
            data_q <= i_vram_dout;             // Read data lands here
        end
    end

    always_ff @(posedge CLK_12MHZ) begin
        if (i_rst) begin
            o_running <= 1'b0;
            blank_q   <= 1'b0;
            step_q    <= 2'd0;
            row_q     <= '0;
            col_q     <= '0;
        end else if (i_start) begin
            o_running <= 1'b1;
            blank_q   <= 1'b0;
            step_q    <= 2'd0;
            row_q     <= '0;
            col_q     <= '0;
        end else if (o_running) begin
            if (!blank_q && (step_q != 2'd2)) begin
                step_q <= step_q + 2'd1;
            end else begin
                step_q <= 2'd0;                // Cell done, next one
                if (col_q == COL_W'(N_COLS - 1)) begin
                    col_q <= '0;
                    if (blank_q) begin
                        o_running <= 1'b0;     // Row 16 blank, finished
                    end else begin
                        row_q <= row_q + 1'b1;
                        if (row_q == ROW_W'(N_ROWS - 2)) begin
                            blank_q <= 1'b1;   // Rows 0..15 copied
                        end
                    end
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    // Data from a read is only usable two clocks later, through data_q
    a_no_write_after_read: assert property (@(posedge CLK_12MHZ) disable iff (i_rst)
        rd |=> !o_vram_we);

endmodule

// ==== source/terminal_ctrl.sv ====
`timescale 1ns/1ps

module terminal_ctrl
    import text_term_pkg::*;
(
    input  logic              CLK_12MHZ,
    input  logic              i_rst,
    input  logic              i_put,           // Put key pulse
    input  logic              i_clear,         // Clear key pulse
    input  logic [7:0]        i_char,
    output logic [ROW_W-1:0]  o_cursor_row,
    output logic [COL_W-1:0]  o_cursor_col,
    output logic              o_clear_start,
    input  logic              i_clear_running,
    output logic              o_scroll_start,
    input  logic              i_scroll_running,
    input  logic [ADDR_W-1:0] i_clear_addr,
    input  logic              i_clear_ce,
    input  logic              i_clear_we,
    input  logic [7:0]        i_clear_din,
    input  logic [ADDR_W-1:0] i_scroll_addr,
    input  logic              i_scroll_ce,
    input  logic              i_scroll_we,
    input  logic [7:0]        i_scroll_din,
    output logic [ADDR_W-1:0] o_vram_addr,
    output logic              o_vram_ce,
    output logic              o_vram_we,
    output logic [7:0]        o_vram_din,
    output logic [7:0]        o_scroll_dout,   // Read data back to scroll
    input  logic [7:0]        i_vram_dout
);

    logic       init_pend;                     // Clear owed since reset
    logic       busy;                          // Engine starting or running
    logic       clear_go;
    logic       put_go;
    logic       put_we;                        // Put write in this clock
    vram_addr_u put_addr;
    logic [7:0] put_char;

    assign busy     = i_clear_running || i_scroll_running || o_clear_start || o_scroll_start;
    assign clear_go = init_pend || (i_clear && !busy);
    assign put_go   = i_put && !busy && !clear_go;   // Clear wins a tie

    always_ff @(posedge CLK_12MHZ) begin
        if (i_rst) begin
            init_pend      <= 1'b1;
            o_clear_start  <= 1'b0;
            o_scroll_start <= 1'b0;
            put_we         <= 1'b0;
            o_cursor_row   <= '0;
            o_cursor_col   <= '0;
        end else begin
            o_clear_start  <= 1'b0;
            o_scroll_start <= 1'b0;
            put_we         <= put_go;
            if (clear_go) begin
                init_pend     <= 1'b0;
                o_clear_start <= 1'b1;
                o_cursor_row  <= '0;           // Home
                o_cursor_col  <= '0;
            end else if (put_go) begin
                if (o_cursor_col == COL_W'(N_COLS - 1)) begin
                    o_cursor_col <= '0;        // Wrap
                    if (o_cursor_row == ROW_W'(N_ROWS - 1)) begin
                        o_scroll_start <= 1'b1;  // Bottom row, scroll instead
                    end else begin
                        o_cursor_row <= o_cursor_row + 1'b1;
                    end
                end else begin
                    o_cursor_col <= o_cursor_col + 1'b1;
                end
            end
        end
    end

    // Cell and character latched with the old cursor
    always_ff @(posedge CLK_12MHZ) begin
        if (put_go) begin
            put_addr.rc.row <= o_cursor_row;
            put_addr.rc.col <= o_cursor_col;
            put_char        <= i_char;
        end
    end

    // Port A owner: scroll, then clear, then put
    always_comb begin
        if (i_scroll_running) begin
            o_vram_addr = i_scroll_addr;
            o_vram_ce   = i_scroll_ce;
            o_vram_we   = i_scroll_we;
            o_vram_din  = i_scroll_din;
        end else if (i_clear_running) begin
            o_vram_addr = i_clear_addr;
            o_vram_ce   = i_clear_ce;
            o_vram_we   = i_clear_we;
            o_vram_din  = i_clear_din;
        end else begin
            o_vram_addr = put_addr.linear;
            o_vram_ce   = put_we;
            o_vram_we   = put_we;
            o_vram_din  = put_char;
        end
    end

    assign o_scroll_dout = i_scroll_running ? i_vram_dout : '0;

    // Both engines on port A at once would lose writes
    a_engines_exclusive: assert property (@(posedge CLK_12MHZ) disable iff (i_rst)
        !(i_clear_running && i_scroll_running));

endmodule

// ==== source/text_scan.sv ====
`timescale 1ns/1ps

module text_scan
    import text_term_pkg::*;
(
    input  logic              CLK_12MHZ,
    input  logic              i_rst,
    input  logic [ROW_W-1:0]  i_cursor_row,
    input  logic [COL_W-1:0]  i_cursor_col,
    output logic [ADDR_W-1:0] o_vram_addr,     // Port B, one clock ahead
    input  logic [7:0]        i_vram_dout,
    output logic [7:0]        o_char,          // Valid while o_den high
    output logic              o_cursor,
    output logic              o_den,
    output logic              o_hsync,
    output logic              o_vsync
);

    logic [$clog2(N_COLS + H_BLANK)-1:0]       h_cnt;   // Clock within line
    logic [$clog2(N_ROWS + V_BLANK_LINES)-1:0] v_cnt;   // Line within frame
    logic                                      active;  // Visible cell
    vram_addr_u                                scan_addr;

    assign active = (h_cnt < N_COLS) && (v_cnt < N_ROWS);

    always_ff @(posedge CLK_12MHZ) begin
        if (i_rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == N_COLS + H_BLANK - 1) begin
            h_cnt <= '0;                       // End of line
            if (v_cnt == N_ROWS + V_BLANK_LINES - 1) begin
                v_cnt <= '0;                   // End of frame
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_comb begin
        scan_addr.rc.row = v_cnt[ROW_W-1:0];
        scan_addr.rc.col = h_cnt[COL_W-1:0];
    end

    assign o_vram_addr = scan_addr.linear;

    // Strobes and cursor one clock late, level with read data
    always_ff @(posedge CLK_12MHZ) begin
        if (i_rst) begin
            o_den    <= 1'b0;
            o_hsync  <= 1'b0;
            o_vsync  <= 1'b0;
            o_cursor <= 1'b0;
        end else begin
            o_den    <= active;
            o_hsync  <= (h_cnt == N_COLS);     // First blank clock
            o_vsync  <= (v_cnt == N_ROWS);     // Whole first blank line
            o_cursor <= active && (v_cnt == i_cursor_row) && (h_cnt == i_cursor_col);
        end
    end

    assign o_char = i_vram_dout;

endmodule

// ==== source/text_term.sv ====
`timescale 1ns/1ps

module text_term
    import text_term_pkg::*;
(
    input  logic              CLK_12MHZ,
    input  logic              i_rst,
    input  logic [N_KEYS-1:0] i_btn,           // Debounced buttons
    input  logic [7:0]        i_char,          // Character for key 0
    output logic [7:0]        o_char,
    output logic              o_cursor,
    output logic              o_den,
    output logic              o_hsync,
    output logic              o_vsync
);

    logic [N_KEYS-1:0] key_pulse;
    logic [ROW_W-1:0]  cursor_row;
    logic [COL_W-1:0]  cursor_col;
    logic              clear_start, clear_running, clear_ce, clear_we;
    logic              scroll_start, scroll_running, scroll_ce, scroll_we;
    logic [ADDR_W-1:0] clear_addr, scroll_addr, a_addr, b_addr;
    logic [7:0]        clear_din, scroll_din, scroll_dout;
    logic              a_ce, a_we;
    logic [7:0]        a_din, a_dout, b_dout;

    for (genvar k = 0; k < N_KEYS; k++) begin : g_key
        key_repeat #(.P_REPEAT(KEY_REPEAT_TICKS[k])) key_repeat_inst (
            .CLK_12MHZ(CLK_12MHZ), .i_rst(i_rst), .i_btn(i_btn[k]), .o_pulse(key_pulse[k])
        );
    end

    terminal_ctrl terminal_ctrl_inst (
        .CLK_12MHZ(CLK_12MHZ), .i_rst(i_rst),
        .i_put(key_pulse[KEY_PUT]), .i_clear(key_pulse[KEY_CLEAR]), .i_char(i_char),
        .o_cursor_row(cursor_row), .o_cursor_col(cursor_col),
        .o_clear_start(clear_start), .i_clear_running(clear_running),
        .o_scroll_start(scroll_start), .i_scroll_running(scroll_running),
        .i_clear_addr(clear_addr), .i_clear_ce(clear_ce),
        .i_clear_we(clear_we), .i_clear_din(clear_din),
        .i_scroll_addr(scroll_addr), .i_scroll_ce(scroll_ce),
        .i_scroll_we(scroll_we), .i_scroll_din(scroll_din),
        .o_vram_addr(a_addr), .o_vram_ce(a_ce), .o_vram_we(a_we), .o_vram_din(a_din),
        .o_scroll_dout(scroll_dout), .i_vram_dout(a_dout)
    );

    clear_engine clear_engine_inst (
        .CLK_12MHZ(CLK_12MHZ), .i_rst(i_rst), .i_start(clear_start),
        .o_running(clear_running), .o_vram_addr(clear_addr), .o_vram_ce(clear_ce),
        .o_vram_we(clear_we), .o_vram_din(clear_din)
    );

    scroll_engine scroll_engine_inst (
        .CLK_12MHZ(CLK_12MHZ), .i_rst(i_rst), .i_start(scroll_start),
        .o_running(scroll_running), .o_vram_addr(scroll_addr), .o_vram_ce(scroll_ce),
        .o_vram_we(scroll_we), .i_vram_dout(scroll_dout), .o_vram_din(scroll_din)
    );

    vram vram_inst (
        .CLK_12MHZ(CLK_12MHZ), .i_a_ce(a_ce), .i_a_we(a_we), .i_a_addr(a_addr),
        .i_a_din(a_din), .o_a_dout(a_dout), .i_b_addr(b_addr), .o_b_dout(b_dout)
    );

    text_scan text_scan_inst (
        .CLK_12MHZ(CLK_12MHZ), .i_rst(i_rst),
        .i_cursor_row(cursor_row), .i_cursor_col(cursor_col),
        .o_vram_addr(b_addr), .i_vram_dout(b_dout), .o_char(o_char),
        .o_cursor(o_cursor), .o_den(o_den), .o_hsync(o_hsync), .o_vsync(o_vsync)
    );

endmodule

// ==== include/text_term_checks.svh ====
`ifndef TEXT_TERM_CHECKS_SVH
`define TEXT_TERM_CHECKS_SVH

// Wrong value seen on the DUT outputs, stops the run
task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("tests failed");
    $fatal(1, "%s", msg);
endtask

// A wait loop ran out of clocks
task automatic report_timeout(input string what);
    $display("Timed out at %0t ns waiting for %s", $time, what);
    $display("tests failed");
    $fatal(1, "timeout waiting for %s", what);
endtask

task automatic report_pass();
    $display("all tests passed");
endtask

// Character code on o_char
task automatic check_char(input logic [7:0] got, input logic [7:0] exp, input string where);
    if (got !== exp) begin
        report_mismatch($sformatf("%s: o_char %02h, expected %02h", where, got, exp));
    end
endtask

// Cursor flag on o_cursor
task automatic check_cursor(input logic got, input logic exp, input string where);
    if (got !== exp) begin
        report_mismatch($sformatf("%s: o_cursor %b, expected %b", where, got, exp));
    end
endtask

// Any one-bit strobe, named by the caller
task automatic check_strobe(input string name, input logic got, input logic exp,
                            input string where);
    if (got !== exp) begin
        report_mismatch($sformatf("%s: %s %b, expected %b", where, name, got, exp));
    end
endtask

`endif

// ==== test/text_term_tb.sv ====
`timescale 1ns/1ps

module text_term_tb
    import text_term_pkg::*;
;

    typedef struct packed {
        int         key;                       // Button index
        logic [7:0] ch;                        // Character on i_char
        int         hold;                      // Clocks the button stays high
        logic       check;                     // Settle and check a frame after
    } entry_t;

    logic              CLK_12MHZ;
    logic              i_rst;
    logic [N_KEYS-1:0] i_btn;
    logic [7:0]        i_char;
    logic [7:0]        o_char;
    logic              o_cursor;
    logic              o_den;
    logic              o_hsync;
    logic              o_vsync;

    logic [7:0] screen [N_ROWS][N_COLS];       // Reference screen
    int         cur_row;
    int         cur_col;
    bit         engine_busy;                   // Clear or scroll in flight

    entry_t stim [11] = '{
        '{0, 8'h48, 4, 1'b1},                  // H
        '{0, 8'h69, 4, 1'b1},                  // i
        '{0, 8'h21, 4, 1'b1},                  // !
        '{0, 8'h61, 2361, 1'b1},               // 60 puts wrap to row 1
        '{0, 8'h62, 38201, 1'b1},              // Fill up to row 16 col 59
        '{0, 8'h7a, 4, 1'b1},                  // Last cell starts a scroll
        '{0, 8'h71, 4, 1'b1},                  // Bottom row after scroll
        '{1, 8'h00, 4, 1'b0},                  // Clear
        '{0, 8'h78, 4, 1'b0},                  // Lands inside the clear
        '{0, 8'h79, 50, 1'b1},                 // Two pulses both dropped
        '{0, 8'h6b, 4, 1'b1}                   // Home cell after clear
    };

    `include "text_term_checks.svh"

    text_term text_term_inst (
        .CLK_12MHZ(CLK_12MHZ), .i_rst(i_rst), .i_btn(i_btn), .i_char(i_char),
        .o_char(o_char), .o_cursor(o_cursor), .o_den(o_den),
        .o_hsync(o_hsync), .o_vsync(o_vsync)
    );

    initial begin
        CLK_12MHZ = 1'b0;
        forever #10 CLK_12MHZ = ~CLK_12MHZ;    // 20 ns period
    end

    function automatic int frame_clocks();
        return (N_COLS + H_BLANK) * (N_ROWS + V_BLANK_LINES);
    endfunction

    function automatic void model_clear();
        for (int r = 0; r < N_ROWS; r++) begin
            for (int c = 0; c < N_COLS; c++) begin
                screen[r][c] = BLANK_CHAR;
            end
        end
        cur_row = 0;                           // Home
        cur_col = 0;
    endfunction

    function automatic void model_scroll();
        for (int r = 0; r < N_ROWS - 1; r++) begin
            for (int c = 0; c < N_COLS; c++) begin
                screen[r][c] = screen[r + 1][c];
            end
        end
        for (int c = 0; c < N_COLS; c++) begin
            screen[N_ROWS - 1][c] = BLANK_CHAR;  // New bottom row
        end
    endfunction

    // One key pulse applied to the reference screen
    function automatic void model_pulse(input int key, input logic [7:0] ch);
        if (engine_busy) begin
            return;                            // Dropped with no queue
        end
        if (key == KEY_CLEAR) begin
            model_clear();
            engine_busy = 1'b1;
        end else begin
            screen[cur_row][cur_col] = ch;
            if (cur_col == N_COLS - 1) begin
                cur_col = 0;
                if (cur_row == N_ROWS - 1) begin
                    model_scroll();            // Cursor stays on bottom row
                    engine_busy = 1'b1;
                end else begin
                    cur_row++;
                end
            end else begin
                cur_col++;
            end
        end
    endfunction

    task automatic press_key(input entry_t e);
        int n_pulses;
        n_pulses = 1 + (e.hold - 1) / int'(KEY_REPEAT_TICKS[e.key]);  // Press plus repeats
        @(posedge CLK_12MHZ);
        #2;
        i_char       = e.ch;
        i_btn[e.key] = 1'b1;
        repeat (e.hold) @(posedge CLK_12MHZ);
        #2;
        i_btn = '0;
        repeat (6) @(posedge CLK_12MHZ);       // Edge register sees the release
        for (int p = 0; p < n_pulses; p++) begin
            model_pulse(e.key, e.ch);
        end
    endtask

    task automatic wait_vsync_level(input logic lvl);
        int n;
        n = 0;
        @(negedge CLK_12MHZ);
        while (o_vsync !== lvl) begin
            @(negedge CLK_12MHZ);
            n++;
            if (n > 2 * frame_clocks()) begin
                report_timeout($sformatf("o_vsync to go %b", lvl));
            end
        end
    endtask

    task automatic wait_first_cell();
        int n;
        n = 0;
        while (o_den !== 1'b1) begin
            @(negedge CLK_12MHZ);
            n++;
            if (n > 2 * frame_clocks()) begin
                report_timeout("o_den to start a frame");
            end
        end
    endtask

    // Enough whole frames for the longest engine run to end
    task automatic wait_frames(input int n);
        repeat (n) begin
            wait_vsync_level(1'b0);
            wait_vsync_level(1'b1);
        end
        engine_busy = 1'b0;
    endtask

    task automatic check_frame(input string tag);
        string where;
        logic  exp_den;
        wait_vsync_level(1'b1);
        wait_first_cell();                     // Now on row 0 col 0
        for (int ln = 0; ln < N_ROWS + V_BLANK_LINES; ln++) begin
            for (int h = 0; h < N_COLS + H_BLANK; h++) begin
                where   = $sformatf("%s line %0d clock %0d", tag, ln, h);
                exp_den = (ln < N_ROWS) && (h < N_COLS);
                check_strobe("o_den", o_den, exp_den, where);
                check_strobe("o_hsync", o_hsync, h == N_COLS, where);
                check_strobe("o_vsync", o_vsync, ln == N_ROWS, where);
                check_cursor(o_cursor, exp_den && (ln == cur_row) && (h == cur_col), where);
                if (exp_den) begin
                    check_char(o_char, screen[ln][h], where);
                end
                @(negedge CLK_12MHZ);
            end
        end
        // Next frame starts right after the last blank line
        check_strobe("o_den", o_den, 1'b1, $sformatf("%s next frame", tag));
    endtask

    initial begin
        i_rst       = 1'b1;
        i_btn       = '0;
        i_char      = '0;
        engine_busy = 1'b0;
        model_clear();                         // Reset clears the screen
        repeat (5) @(posedge CLK_12MHZ);
        #2;
        i_rst = 1'b0;
        wait_frames(3);
        check_frame("after reset");
        for (int i = 0; i < $size(stim); i++) begin
            press_key(stim[i]);
            if (stim[i].check) begin
                wait_frames(3);
                check_frame($sformatf("entry %0d", i));
            end
        end
        report_pass();
        $finish;
    end

endmodule

// ==== text_term.f ====
+incdir+include
source/text_term_pkg.sv
source/key_repeat.sv
source/vram.sv
source/clear_engine.sv
source/scroll_engine.sv
source/terminal_ctrl.sv
source/text_scan.sv
source/text_term.sv
test/text_term_tb.sv

// ==== Bender.yml ====
package:
  name: text_term

sources:
  - include_dirs:
      - include
    files:
      - source/text_term_pkg.sv
      - source/key_repeat.sv
      - source/vram.sv
      - source/clear_engine.sv
      - source/scroll_engine.sv
      - source/terminal_ctrl.sv
      - source/text_scan.sv
      - source/text_term.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/text_term_tb.sv
